//--- hdl/sib_pkg.sv
/*
  SampleInBall shared definitions
  Modulus, coefficient memory geometry, word and request types, FSM states
*/
package sib_pkg;

  // Dilithium modulus, a coefficient of -1 is stored as q-1
  localparam int DILITHIUM_Q = 8380417;
  localparam int COEFF_W = 23;

  // Challenge polynomial and memory geometry
  localparam int NUM_COEFF = 256;
  localparam int MEM_LANES = 4;
  localparam int MEM_ADDR_W = 6;

  typedef logic [COEFF_W-1:0] coeff_t;

  // One memory word, four coefficients side by side
  typedef struct packed {
    coeff_t [MEM_LANES-1:0] lane;
  } mem_word_t;

  // Request on one design port of the coefficient memory
  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    mem_word_t             wrdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    SIB_IDLE,
    SIB_SIGN_BUFFER,
    SIB_ACTIVE,
    SIB_DONE
  } sib_fsm_state_e;

  typedef enum logic {
    SHUF_IDLE,
    SHUF_WRITE
  } shuf_state_e;

endpackage

//--- hdl/sib_coeff_mem.sv
/*
  Coefficient memory, 64 words of four coefficients
  Two design ports and a host read port, all reads registered
*/
module sib_coeff_mem (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic                              zeroize_i,
  input  sib_pkg::mem_req_t [1:0]           req_i,
  output sib_pkg::mem_word_t [1:0]          rddata_o,
  input  logic                              host_rd_en_i,
  input  logic [sib_pkg::MEM_ADDR_W-1:0]    host_rd_addr_i,
  output sib_pkg::mem_word_t                host_rd_data_o
);

  localparam int DEPTH = sib_pkg::NUM_COEFF / sib_pkg::MEM_LANES;

  sib_pkg::mem_word_t mem_q [DEPTH];

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem_q[w] <= '0;
      end
    end else if (zeroize_i) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      // Port 0 written last so it wins on a shared address
      if (req_i[1].cs && req_i[1].we) begin
        mem_q[req_i[1].addr] <= req_i[1].wrdata;
      end
      if (req_i[0].cs && req_i[0].we) begin
        mem_q[req_i[0].addr] <= req_i[0].wrdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (req_i[p].cs && !req_i[p].we) begin
        rddata_o[p] <= mem_q[req_i[p].addr];
      end
    end
    if (host_rd_en_i) begin
      host_rd_data_o <= mem_q[host_rd_addr_i];
    end
  end

endmodule

//--- hdl/sib_shuffler.sv
/*
  SampleInBall swap shuffler
  Read-modify-write of coefficients i and j over two cycles,
  merging both updates into one write when they share a word
*/
module sib_shuffler #(
  parameter int SIB_SAMPLE_W = 8
) (
  input  logic                     clk,
  input  logic                     rst_b,
  input  logic                     zeroize_i,
  input  logic                     valid_i,
  input  logic [SIB_SAMPLE_W-1:0]  index_i_i,
  input  logic [SIB_SAMPLE_W-1:0]  index_j_i,
  input  logic                     sign_i,
  output logic                     hold_o,
  output sib_pkg::mem_req_t [1:0]  mem_req_o,
  input  sib_pkg::mem_word_t [1:0] rddata_i
);

  localparam int LANE_BITS = $clog2(sib_pkg::MEM_LANES);
  localparam sib_pkg::coeff_t COEFF_PLUS  = sib_pkg::coeff_t'(1);
  localparam sib_pkg::coeff_t COEFF_MINUS = sib_pkg::coeff_t'(sib_pkg::DILITHIUM_Q - 1);

  sib_pkg::shuf_state_e state_q;
  sib_pkg::shuf_state_e state_d;

  logic [SIB_SAMPLE_W-1:0] idx_i_q;
  logic [SIB_SAMPLE_W-1:0] idx_j_q;
  logic                    sign_q;
  logic                    accept;
  logic [LANE_BITS-1:0]    lane_i;
  logic [LANE_BITS-1:0]    lane_j;
  logic                    same_word;
  sib_pkg::coeff_t         old_j;
  sib_pkg::coeff_t         sign_val;
  sib_pkg::mem_word_t      word_i;
  sib_pkg::mem_word_t      word_j;

  // Word address of a coefficient index
  function automatic logic [sib_pkg::MEM_ADDR_W-1:0] word_addr(
    input logic [SIB_SAMPLE_W-1:0] idx
  );
    return idx[LANE_BITS +: sib_pkg::MEM_ADDR_W];
  endfunction

  assign accept = valid_i & (state_q == sib_pkg::SHUF_IDLE);
  assign hold_o = (state_q == sib_pkg::SHUF_WRITE);

  assign state_d = accept ? sib_pkg::SHUF_WRITE : sib_pkg::SHUF_IDLE;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= sib_pkg::SHUF_IDLE;
    end else if (zeroize_i) begin
      state_q <= sib_pkg::SHUF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      idx_i_q <= '0;
      idx_j_q <= '0;
      sign_q  <= 1'b0;
    end else if (zeroize_i) begin
      idx_i_q <= '0;
      idx_j_q <= '0;
      sign_q  <= 1'b0;
    end else if (accept) begin
      idx_i_q <= index_i_i;
      idx_j_q <= index_j_i;
      sign_q  <= sign_i;
    end
  end

  assign lane_i    = idx_i_q[LANE_BITS-1:0];
  assign lane_j    = idx_j_q[LANE_BITS-1:0];
  assign same_word = (word_addr(idx_i_q) == word_addr(idx_j_q));
  assign old_j     = rddata_i[0].lane[lane_j];
  assign sign_val  = sign_q ? COEFF_MINUS : COEFF_PLUS;

  // Shared word goes out on port 0 only; sign value lands last so i == j keeps it
  always_comb begin
    word_j = rddata_i[0];
    word_i = rddata_i[1];
    if (same_word) begin
      word_j.lane[lane_i] = old_j;
    end else begin
      word_i.lane[lane_i] = old_j;
    end
    word_j.lane[lane_j] = sign_val;
  end

  always_comb begin
    mem_req_o = '0;
    if (accept) begin
      mem_req_o[0].cs   = 1'b1;
      mem_req_o[0].addr = word_addr(index_j_i);
      mem_req_o[1].cs   = 1'b1;
      mem_req_o[1].addr = word_addr(index_i_i);
    end else if (hold_o) begin
      mem_req_o[0].cs     = 1'b1;
      mem_req_o[0].we     = 1'b1;
      mem_req_o[0].addr   = word_addr(idx_j_q);
      mem_req_o[0].wrdata = word_j;
      mem_req_o[1].cs     = ~same_word;
      mem_req_o[1].we     = ~same_word;
      mem_req_o[1].addr   = word_addr(idx_i_q);
      mem_req_o[1].wrdata = word_i;
    end
  end

endmodule

//--- hdl/sample_in_ball_ctrl.sv
/*
  SampleInBall controller
  Gathers the sign bits, scans each beat for bytes not above index i
  and hands every accepted byte to the swap shuffler
*/
module sample_in_ball_ctrl #(
  parameter int SIB_NUM_SAMPLERS = 4,
  parameter int SIB_SAMPLE_W     = 8,
  parameter int SIB_TAU          = 60
) (
  input  logic                                          clk,
  input  logic                                          rst_b,
  input  logic                                          zeroize_i,
  input  logic                                          data_valid_i,
  input  logic [SIB_NUM_SAMPLERS-1:0][SIB_SAMPLE_W-1:0] data_i,
  output logic                                          data_hold_o,
  output logic                                          sib_done_o,
  output sib_pkg::mem_req_t [1:0]                       mem_req_o,
  input  sib_pkg::mem_word_t [1:0]                      rddata_i
);

  localparam int BEAT_W = SIB_NUM_SAMPLERS * SIB_SAMPLE_W;
  localparam int LANE_IDX_W = (SIB_NUM_SAMPLERS > 1) ? $clog2(SIB_NUM_SAMPLERS) : 1;
  // One extra bit so the index can step past 255 and flag completion
  localparam int IDX_W = SIB_SAMPLE_W + 1;
  localparam logic [IDX_W-1:0] IDX_START = IDX_W'(sib_pkg::NUM_COEFF - SIB_TAU);
  localparam logic [LANE_IDX_W-1:0] LAST_LANE = LANE_IDX_W'(SIB_NUM_SAMPLERS - 1);

  sib_pkg::sib_fsm_state_e state_q;
  sib_pkg::sib_fsm_state_e state_d;

  logic [SIB_TAU-1:0]          sign_q;
  logic [2*BEAT_W-1:0]         sign_beat;
  logic                        sign_load;
  logic [IDX_W-1:0]            rej_idx_q;
  logic [SIB_NUM_SAMPLERS-1:0] lane_ok;
  logic [SIB_NUM_SAMPLERS-1:0] lane_mask_q;
  logic [SIB_NUM_SAMPLERS-1:0] lane_mask_d;
  logic                        index_found;
  logic [LANE_IDX_W-1:0]       found_lane;
  logic [SIB_SAMPLE_W-1:0]     found_byte;
  logic                        lane_hold;
  logic                        active;
  logic                        shuf_hold;
  logic                        swap_accept;

  always_comb begin
    state_d = state_q;
    case (state_q)
      sib_pkg::SIB_IDLE: begin
        if (data_valid_i) begin
          state_d = sib_pkg::SIB_SIGN_BUFFER;
        end
      end
      sib_pkg::SIB_SIGN_BUFFER: begin
        if (data_valid_i) begin
          state_d = sib_pkg::SIB_ACTIVE;
        end
      end
      sib_pkg::SIB_ACTIVE: begin
        // Index past 255 means the last swap is in its write cycle
        if (rej_idx_q[IDX_W-1]) begin
          state_d = sib_pkg::SIB_DONE;
        end
      end
      sib_pkg::SIB_DONE: state_d = sib_pkg::SIB_DONE;
      default: state_d = sib_pkg::SIB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= sib_pkg::SIB_IDLE;
    end else if (zeroize_i) begin
      state_q <= sib_pkg::SIB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign active     = (state_q == sib_pkg::SIB_ACTIVE);
  assign sib_done_o = (state_q == sib_pkg::SIB_DONE);

  // First beat lands in the low bits, second beat above it
  assign sign_load = data_valid_i & ((state_q == sib_pkg::SIB_IDLE) |
                                     (state_q == sib_pkg::SIB_SIGN_BUFFER));
  assign sign_beat = (state_q == sib_pkg::SIB_SIGN_BUFFER) ? {data_i, {BEAT_W{1'b0}}}
                                                           : {{BEAT_W{1'b0}}, data_i};

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_q <= '0;
    end else if (zeroize_i) begin
      sign_q <= '0;
    end else if (sign_load) begin
      sign_q <= sign_q | sign_beat[SIB_TAU-1:0];
    end else if (swap_accept) begin
      sign_q <= sign_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rej_idx_q <= IDX_START;
    end else if (zeroize_i) begin
      rej_idx_q <= IDX_START;
    end else if (swap_accept) begin
      rej_idx_q <= rej_idx_q + 1'b1;
    end
  end

  // Rejection test per lane, masked lanes were already used on this beat
  always_comb begin
    for (int l = 0; l < SIB_NUM_SAMPLERS; l++) begin
      lane_ok[l] = active & data_valid_i & lane_mask_q[l] &
                   ({1'b0, data_i[l]} <= rej_idx_q);
    end
  end

  // Lowest acceptable lane wins; that lane and all below it get masked
  always_comb begin
    index_found = 1'b0;
    found_lane  = '0;
    lane_mask_d = lane_mask_q;
    for (int l = 0; l < SIB_NUM_SAMPLERS; l++) begin
      if (!index_found) begin
        lane_mask_d[l] = 1'b0;
        if (lane_ok[l]) begin
          index_found = 1'b1;
          found_lane  = LANE_IDX_W'(l);
        end
      end
    end
  end

  assign found_byte  = data_i[found_lane];
  assign lane_hold   = index_found & (found_lane != LAST_LANE);
  assign swap_accept = index_found & ~shuf_hold;
  assign data_hold_o = active & (shuf_hold | lane_hold);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      lane_mask_q <= '1;
    end else if (zeroize_i || !active) begin
      lane_mask_q <= '1;
    end else if (data_valid_i && !shuf_hold) begin
      // Rescan the same beat, or open the next one with all lanes
      if (lane_hold) begin
        lane_mask_q <= lane_mask_d;
      end else begin
        lane_mask_q <= '1;
      end
    end
  end

  sib_shuffler #(
    .SIB_SAMPLE_W(SIB_SAMPLE_W)
  ) u_shuffler (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .valid_i   (index_found),
    .index_i_i (rej_idx_q[SIB_SAMPLE_W-1:0]),
    .index_j_i (found_byte),
    .sign_i    (sign_q[0]),
    .hold_o    (shuf_hold),
    .mem_req_o (mem_req_o),
    .rddata_i  (rddata_i)
  );

endmodule

//--- hdl/sib_top.sv
/*
  SampleInBall top level
  Controller plus coefficient memory with host read-out
*/
module sib_top #(
  parameter int SIB_NUM_SAMPLERS = 4,
  parameter int SIB_SAMPLE_W     = 8,
  parameter int SIB_TAU          = 60
) (
  input  logic                                          clk,
  input  logic                                          rst_b,
  input  logic                                          zeroize_i,
  input  logic                                          data_valid_i,
  input  logic [SIB_NUM_SAMPLERS-1:0][SIB_SAMPLE_W-1:0] data_i,
  output logic                                          data_hold_o,
  output logic                                          sib_done_o,
  input  logic                                          host_rd_en_i,
  input  logic [sib_pkg::MEM_ADDR_W-1:0]                host_rd_addr_i,
  output sib_pkg::mem_word_t                            host_rd_data_o
);

  sib_pkg::mem_req_t [1:0]  mem_req;
  sib_pkg::mem_word_t [1:0] mem_rddata;

  sample_in_ball_ctrl #(
    .SIB_NUM_SAMPLERS (SIB_NUM_SAMPLERS),
    .SIB_SAMPLE_W     (SIB_SAMPLE_W),
    .SIB_TAU          (SIB_TAU)
  ) u_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .data_hold_o  (data_hold_o),
    .sib_done_o   (sib_done_o),
    .mem_req_o    (mem_req),
    .rddata_i     (mem_rddata)
  );

  sib_coeff_mem u_mem (
    .clk            (clk),
    .rst_b          (rst_b),
    .zeroize_i      (zeroize_i),
    .req_i          (mem_req),
    .rddata_o       (mem_rddata),
    .host_rd_en_i   (host_rd_en_i),
    .host_rd_addr_i (host_rd_addr_i),
    .host_rd_data_o (host_rd_data_o)
  );

endmodule

//--- tb/sib_chk.sv
/*
  SampleInBall controller checks
  Concurrent assertions on hold, done and memory request behavior
*/
module sib_chk (
  input logic                    clk,
  input logic                    rst_b,
  input logic                    zeroize_i,
  input logic                    data_hold_o,
  input logic                    sib_done_o,
  input logic                    shuf_hold,
  input sib_pkg::sib_fsm_state_e state_q,
  input sib_pkg::mem_req_t [1:0] mem_req_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_errs = 0;

  // Source is only stalled while sample beats are scanned
  hold_in_active: assert property (@(posedge clk) disable iff (!rst_b)
    data_hold_o |-> (state_q == sib_pkg::SIB_ACTIVE))
  else begin
    assert_errs++;
    $error("data_hold_o high outside SIB_ACTIVE");
  end

  // Done is sticky until zeroize
  done_sticky: assert property (@(posedge clk) disable iff (!rst_b)
    $fell(sib_done_o) |-> $past(zeroize_i))
  else begin
    assert_errs++;
    $error("sib_done_o fell without zeroize_i");
  end

  // Write phase of a swap is a single cycle
  shuf_hold_single: assert property (@(posedge clk) disable iff (!rst_b)
    shuf_hold |=> !shuf_hold)
  else begin
    assert_errs++;
    $error("shuffler hold lasted more than one cycle");
  end

  idle_no_mem: assert property (@(posedge clk) disable iff (!rst_b)
    (state_q == sib_pkg::SIB_IDLE) |-> !(mem_req_o[0].cs || mem_req_o[1].cs))
  else begin
    assert_errs++;
    $error("memory chip select active in SIB_IDLE");
  end

endmodule

bind sample_in_ball_ctrl sib_chk u_chk (
  .clk         (clk),
  .rst_b       (rst_b),
  .zeroize_i   (zeroize_i),
  .data_hold_o (data_hold_o),
  .sib_done_o  (sib_done_o),
  .shuf_hold   (shuf_hold),
  .state_q     (state_q),
  .mem_req_o   (mem_req_o)
);

//--- tb/sib_tb.sv
/*
  SampleInBall testbench
  Runs a table of cases against a software model of the challenge sampler
*/
module sib_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 10;
  localparam int TAU = 60;
  localparam int LANES = 4;
  localparam int ADDR_W = sib_pkg::MEM_ADDR_W;
  localparam int NUM_WORDS = sib_pkg::NUM_COEFF / sib_pkg::MEM_LANES;
  localparam int NUM_CASES = 4;

  typedef struct {
    string name;
    int    seed_off;
    int    stall_pct;
    int    zeroize_at;
    bit    host_rd;
  } case_t;

  logic                  clk;
  logic                  rst_b;
  logic                  zeroize_i;
  logic                  data_valid_i;
  logic [LANES-1:0][7:0] data_i;
  logic                  data_hold_o;
  logic                  sib_done_o;
  logic                  host_rd_en_i;
  logic [ADDR_W-1:0]     host_rd_addr_i;
  sib_pkg::mem_word_t    host_rd_data_o;

  case_t              cases [NUM_CASES];
  logic [8*LANES-1:0] beats [$];
  sib_pkg::coeff_t    exp_c [sib_pkg::NUM_COEFF];
  int                 word_errs;
  int                 bit_errs;
  int                 other_errs;
  int                 assert_errs;
  bit                 stopped;

  sib_top #(
    .SIB_NUM_SAMPLERS (LANES),
    .SIB_SAMPLE_W     (8),
    .SIB_TAU          (TAU)
  ) DUT (
    .clk            (clk),
    .rst_b          (rst_b),
    .zeroize_i      (zeroize_i),
    .data_valid_i   (data_valid_i),
    .data_i         (data_i),
    .data_hold_o    (data_hold_o),
    .sib_done_o     (sib_done_o),
    .host_rd_en_i   (host_rd_en_i),
    .host_rd_addr_i (host_rd_addr_i),
    .host_rd_data_o (host_rd_data_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %0b got %0b", $time, name, exp, act);
      bit_errs++;
    end
  endtask

  task automatic check_word(input string name, input sib_pkg::mem_word_t exp,
                            input sib_pkg::mem_word_t act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %h got %h", $time, name, exp, act);
      word_errs++;
    end
  endtask

  task automatic drive_host_read(input bit en);
    host_rd_en_i   = en;
    host_rd_addr_i = ADDR_W'($urandom_range(NUM_WORDS - 1));
  endtask

  // Software SampleInBall, generates the beats and the expected coefficients
  task automatic build_run();
    int                 i;
    logic [63:0]        signs;
    logic [8*LANES-1:0] beat;
    logic [7:0]         b;
    beats.delete();
    for (int k = 0; k < sib_pkg::NUM_COEFF; k++) begin
      exp_c[k] = '0;
    end
    beat = $urandom;
    beats.push_back(beat);
    signs[31:0] = beat;
    beat = $urandom;
    beats.push_back(beat);
    signs[63:32] = beat;
    i = sib_pkg::NUM_COEFF - TAU;
    while (i < sib_pkg::NUM_COEFF) begin
      for (int l = 0; l < LANES; l++) begin
        // A quarter of the bytes land close to i, so same-word swaps and i == j occur
        if ($urandom_range(3) == 0) begin
          b = 8'(i - int'($urandom_range(3)));
        end else begin
          b = 8'($urandom);
        end
        beat[8*l +: 8] = b;
        if (i < sib_pkg::NUM_COEFF && int'(b) <= i) begin
          exp_c[i] = exp_c[b];
          exp_c[b] = signs[0] ? sib_pkg::coeff_t'(sib_pkg::DILITHIUM_Q - 1)
                              : sib_pkg::coeff_t'(1);
          signs = signs >> 1;
          i++;
        end
      end
      beats.push_back(beat);
    end
  endtask

  // Presents one beat after random gaps and keeps it until it is taken
  task automatic offer_beat(input logic [8*LANES-1:0] beat, input int stall_pct,
                            input bit host);
    while ($urandom_range(99) < stall_pct) begin
      @(negedge clk);
      data_valid_i = 1'b0;
      drive_host_read(host);
    end
    @(negedge clk);
    data_valid_i = 1'b1;
    data_i       = beat;
    drive_host_read(host);
    #1;
    while (data_hold_o) begin
      @(negedge clk);
      drive_host_read(host);
      #1;
    end
  endtask

  task automatic feed_beats(input int stall_pct, input bit host, input int stop_at,
                            output bit stop_hit);
    stop_hit = 1'b0;
    for (int b = 0; b < beats.size(); b++) begin
      if (stop_at != 0 && b == stop_at) begin
        stop_hit = 1'b1;
        break;
      end
      if (b == beats.size() - 1) begin
        check_bit("sib_done_o", 1'b0, sib_done_o);
      end
      offer_beat(beats[b], stall_pct, host);
    end
  endtask

  task automatic zeroize_pulse();
    @(negedge clk);
    data_valid_i = 1'b0;
    host_rd_en_i = 1'b0;
    zeroize_i    = 1'b1;
    @(negedge clk);
    zeroize_i = 1'b0;
    #1;
  endtask

  // Reads all 64 words, one host read at a time
  task automatic read_image(input bit expect_zero);
    sib_pkg::mem_word_t exp_word;
    for (int a = 0; a < NUM_WORDS; a++) begin
      @(negedge clk);
      host_rd_en_i   = 1'b1;
      host_rd_addr_i = ADDR_W'(a);
      @(negedge clk);
      host_rd_en_i = 1'b0;
      for (int l = 0; l < sib_pkg::MEM_LANES; l++) begin
        exp_word.lane[l] = expect_zero ? sib_pkg::coeff_t'(0)
                                       : exp_c[sib_pkg::MEM_LANES*a + l];
      end
      check_word($sformatf("host_rd_data_o[%0d]", a), exp_word, host_rd_data_o);
    end
  endtask

  task automatic check_idle();
    check_bit("sib_done_o", 1'b0, sib_done_o);
    check_bit("data_hold_o", 1'b0, data_hold_o);
    read_image(1'b1);
  endtask

  task automatic finish_run();
    int n;
    n = 0;
    @(negedge clk);
    data_valid_i = 1'b0;
    host_rd_en_i = 1'b0;
    while (!sib_done_o && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!sib_done_o) begin
      $display("ERROR at %0t ns: sib_done_o did not rise after the last beat", $time);
      other_errs++;
    end
    // Beats offered after completion are ignored
    repeat (6) begin
      @(negedge clk);
      data_valid_i = 1'b1;
      data_i       = $urandom;
      #1;
      check_bit("sib_done_o", 1'b1, sib_done_o);
      check_bit("data_hold_o", 1'b0, data_hold_o);
    end
    @(negedge clk);
    data_valid_i = 1'b0;
    read_image(1'b0);
  endtask

  initial begin
    #(NUM_CASES * 4096 * CLK_PERIOD);
    $display("ERROR: run timed out before all cases finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    clk            = 1'b0;
    rst_b          = 1'b0;
    zeroize_i      = 1'b0;
    data_valid_i   = 1'b0;
    data_i         = '0;
    host_rd_en_i   = 1'b0;
    host_rd_addr_i = '0;
    word_errs      = 0;
    bit_errs       = 0;
    other_errs     = 0;
    void'($urandom(32'h9769));
    cases[0] = '{"no_stall", 0, 0, 0, 1'b0};
    cases[1] = '{"stall_30_host_read", 3, 30, 0, 1'b1};
    cases[2] = '{"zeroize_mid_run", 7, 10, 6, 1'b0};
    cases[3] = '{"stall_60_host_read", 11, 60, 0, 1'b1};
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    #1;
    check_idle();
    for (int c = 0; c < NUM_CASES; c++) begin
      $display("Case %0d: %s", c, cases[c].name);
      repeat (cases[c].seed_off) void'($urandom);
      zeroize_pulse();
      check_idle();
      build_run();
      feed_beats(cases[c].stall_pct, cases[c].host_rd, cases[c].zeroize_at, stopped);
      if (stopped) begin
        zeroize_pulse();
        check_idle();
        build_run();
        feed_beats(cases[c].stall_pct, cases[c].host_rd, 0, stopped);
      end
      finish_run();
    end
    assert_errs = DUT.u_ctrl.u_chk.assert_errs;
    $display("Errors: %0d word, %0d bit, %0d other, %0d assertion",
             word_errs, bit_errs, other_errs, assert_errs);
    if (word_errs + bit_errs + other_errs + assert_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/sib_pkg.sv
hdl/sib_coeff_mem.sv
hdl/sib_shuffler.sv
hdl/sample_in_ball_ctrl.sv
hdl/sib_top.sv
tb/sib_chk.sv
tb/sib_tb.sv
